// ==== vout_cfg.svh ====
// Video output stage parameters
`ifndef VOUT_CFG_SVH
`define VOUT_CFG_SVH

// Bits per colour channel
`define VOUT_CH_W 8

// Lane 0 is R, lane 1 is G, lane 2 is B
`define VOUT_NUM_LANES 3

// Input to HDMI port latency in pclk_out cycles
`define VOUT_HDMI_LAT 2

// Input to VGA port latency with extra-out selected
`define VOUT_VGA_LAT 3

`endif

// ==== vout_pkg.sv ====
// Video output types
`default_nettype none

`include "vout_cfg.svh"

package vout_pkg;

    typedef logic [`VOUT_CH_W-1:0] chan_t;

    typedef enum logic [1:0] {
        OSD_BLACK  = 2'd0,
        OSD_BLUE   = 2'd1,
        OSD_YELLOW = 2'd2,
        OSD_WHITE  = 2'd3
    } osd_color_e;

    // Expansion connector usage
    typedef enum logic [1:0] {
        EXP_OFF        = 2'd0,
        EXP_EXTRA_OUT  = 2'd1,
        EXP_LEGACY_IN  = 2'd2,
        EXP_UVC_BRIDGE = 2'd3
    } exp_sel_e;

    typedef enum logic [1:0] {
        EXTRA_RGBHV = 2'd0,
        EXTRA_RGBCS = 2'd1,
        EXTRA_RGSB  = 2'd2,
        EXTRA_YPBPR = 2'd3
    } extra_out_mode_e;

endpackage

`default_nettype wire

// ==== vout_lane_if.sv ====
// Palette to lane bus
`timescale 1ns/1ns
`default_nettype none

`include "vout_cfg.svh"

interface vout_lane_if;

    // Scaler pixel, one channel per lane
    vout_pkg::chan_t sc_val  [`VOUT_NUM_LANES];
    vout_pkg::chan_t osd_val [`VOUT_NUM_LANES];
    logic            osd_active;
    logic            vga_en;

    modport palette_mp (
        output sc_val,
        output osd_val,
        output osd_active,
        output vga_en
    );

    modport lane_mp (
        input sc_val,
        input osd_val,
        input osd_active,
        input vga_en
    );

endinterface

`default_nettype wire

// ==== osd_palette.sv ====
// OSD palette and stage 1 sync
`timescale 1ns/1ns
`default_nettype none

`include "vout_cfg.svh"

module osd_palette (
    input  logic                       pclk_out,
    input  logic                       po_reset_n,
    input  vout_pkg::chan_t            r_i,
    input  vout_pkg::chan_t            g_i,
    input  vout_pkg::chan_t            b_i,
    input  logic                       hsync_i,
    input  logic                       vsync_i,
    input  logic                       de_i,
    input  logic                       osd_enable_i,
    input  vout_pkg::osd_color_e       osd_color_i,
    input  vout_pkg::exp_sel_e         exp_sel_i,
    input  vout_pkg::extra_out_mode_e  extra_out_mode_i,
    vout_lane_if.palette_mp            lane_o,
    output logic                       hs_s1_o,
    output logic                       vs_s1_o,
    output logic                       de_s1_o,
    output logic                       vga_en_s1_o,
    output vout_pkg::extra_out_mode_e  mode_s1_o
);

    localparam int PIX_W = `VOUT_NUM_LANES * `VOUT_CH_W;
    localparam vout_pkg::chan_t CH_OFF = '0;
    localparam vout_pkg::chan_t CH_ON  = '1;

    logic [PIX_W-1:0] osd_rgb;
    logic [PIX_W-1:0] sc_rgb;
    logic             vga_en;

    assign sc_rgb = {r_i, g_i, b_i};
    assign vga_en = (exp_sel_i == vout_pkg::EXP_EXTRA_OUT);

    always_comb begin
        case (osd_color_i)
            vout_pkg::OSD_BLACK:  osd_rgb = {CH_OFF, CH_OFF, CH_OFF};
            vout_pkg::OSD_BLUE:   osd_rgb = {CH_OFF, CH_OFF, CH_ON};
            vout_pkg::OSD_YELLOW: osd_rgb = {CH_ON, CH_ON, CH_OFF};
            default:              osd_rgb = {CH_ON, CH_ON, CH_ON};
        endcase
    end

    // Lane 0 takes the top channel
    for (genvar i = 0; i < `VOUT_NUM_LANES; i++) begin : split_gen
        assign lane_o.sc_val[i]  = sc_rgb[(`VOUT_NUM_LANES-1-i)*`VOUT_CH_W +: `VOUT_CH_W];
        assign lane_o.osd_val[i] = osd_rgb[(`VOUT_NUM_LANES-1-i)*`VOUT_CH_W +: `VOUT_CH_W];
    end

    assign lane_o.osd_active = osd_enable_i;
    assign lane_o.vga_en     = vga_en;

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            hs_s1_o     <= 1'b0;
            vs_s1_o     <= 1'b0;
            de_s1_o     <= 1'b0;
            vga_en_s1_o <= 1'b0;
            mode_s1_o   <= vout_pkg::EXTRA_RGBHV;
        end else begin
            hs_s1_o     <= hsync_i;
            vs_s1_o     <= vsync_i;
            de_s1_o     <= de_i;
            vga_en_s1_o <= vga_en;
            mode_s1_o   <= extra_out_mode_i;
        end
    end

endmodule

`default_nettype wire

// ==== pixel_lane.sv ====
// Per-colour pixel lane
`timescale 1ns/1ns
`default_nettype none

module pixel_lane #(
    parameter int LANE = 0
) (
    input  logic             pclk_out,
    input  logic             po_reset_n,
    vout_lane_if.lane_mp     lane_i,
    output vout_pkg::chan_t  hdmi_o,
    output vout_pkg::chan_t  vga_o
);

    vout_pkg::chan_t pix_s1;
    vout_pkg::chan_t vga_pre;
    logic            vga_en_s1;
    logic            vga_en_s2;

    // Overlay result, stage 1
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            pix_s1    <= '0;
            vga_en_s1 <= 1'b0;
        end else begin
            if (lane_i.osd_active) begin
                pix_s1 <= lane_i.osd_val[LANE];
            end else begin
                pix_s1 <= lane_i.sc_val[LANE];
            end
            vga_en_s1 <= lane_i.vga_en;
        end
    end

    // HDMI transmitter register
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            hdmi_o <= '0;
        end else begin
            hdmi_o <= pix_s1;
        end
    end

    // VGA DAC path one stage behind HDMI
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            vga_pre   <= '0;
            vga_o     <= '0;
            vga_en_s2 <= 1'b0;
        end else begin
            vga_en_s2 <= vga_en_s1;
            if (vga_en_s1) begin
                vga_pre <= pix_s1;
            end
            // Holds while extra-out is off
            if (vga_en_s2) begin
                vga_o <= vga_pre;
            end
        end
    end

endmodule

`default_nettype wire

// ==== sync_encoder.sv ====
// HDMI and VGA sync encoder
`timescale 1ns/1ns
`default_nettype none

module sync_encoder (
    input  logic                       pclk_out,
    input  logic                       po_reset_n,
    input  logic                       hs_s1_i,
    input  logic                       vs_s1_i,
    input  logic                       de_s1_i,
    input  logic                       vga_en_s1_i,
    input  vout_pkg::extra_out_mode_e  mode_s1_i,
    output logic                       hdmi_hsync_o,
    output logic                       hdmi_vsync_o,
    output logic                       hdmi_de_o,
    output logic                       vga_hs_o,
    output logic                       vga_vs_o,
    output logic                       vga_blank_n_o,
    output logic                       vga_sync_n_o,
    output logic                       vga_oe_o
);

    logic csync;
    logic hs_enc;
    logic vs_enc;
    logic blank_n_enc;
    logic sync_n_enc;
    logic hs_pre;
    logic vs_pre;
    logic blank_n_pre;
    logic sync_n_pre;
    logic vga_en_s2;

    assign csync = ~(hs_s1_i ^ vs_s1_i);

    always_comb begin
        hs_enc      = csync;
        vs_enc      = 1'b1;
        blank_n_enc = de_s1_i;
        sync_n_enc  = 1'b0;
        case (mode_s1_i)
            vout_pkg::EXTRA_RGBHV: begin
                hs_enc = hs_s1_i;
                vs_enc = vs_s1_i;
            end
            vout_pkg::EXTRA_RGSB: sync_n_enc = csync;
            // Treated as RGsB sync with blanking kept off
            vout_pkg::EXTRA_YPBPR: begin
                blank_n_enc = 1'b1;
                sync_n_enc  = csync;
            end
            default: sync_n_enc = 1'b0;
        endcase
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            hdmi_hsync_o <= 1'b0;
            hdmi_vsync_o <= 1'b0;
            hdmi_de_o    <= 1'b0;
        end else begin
            hdmi_hsync_o <= hs_s1_i;
            hdmi_vsync_o <= vs_s1_i;
            hdmi_de_o    <= de_s1_i;
        end
    end

    // Same hold rule as the lane VGA registers
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            {hs_pre, vs_pre, blank_n_pre, sync_n_pre} <= 4'b0000;
            {vga_hs_o, vga_vs_o, vga_blank_n_o, vga_sync_n_o} <= 4'b0000;
            vga_en_s2 <= 1'b0;
            vga_oe_o  <= 1'b0;
        end else begin
            vga_en_s2 <= vga_en_s1_i;
            vga_oe_o  <= vga_en_s2;
            if (vga_en_s1_i) begin
                {hs_pre, vs_pre, blank_n_pre, sync_n_pre} <=
                    {hs_enc, vs_enc, blank_n_enc, sync_n_enc};
            end
            if (vga_en_s2) begin
                {vga_hs_o, vga_vs_o, vga_blank_n_o, vga_sync_n_o} <=
                    {hs_pre, vs_pre, blank_n_pre, sync_n_pre};
            end
        end
    end

endmodule

`default_nettype wire

// ==== video_out_top.sv ====
// Video output stage top level
`timescale 1ns/1ns
`default_nettype none

`include "vout_cfg.svh"

// HDMI port is VOUT_HDMI_LAT cycles behind the inputs, VGA port VOUT_VGA_LAT
module video_out_top (
    input  logic                       pclk_out,
    input  logic                       po_reset_n,
    input  vout_pkg::chan_t            r_i,
    input  vout_pkg::chan_t            g_i,
    input  vout_pkg::chan_t            b_i,
    input  logic                       hsync_i,
    input  logic                       vsync_i,
    input  logic                       de_i,
    input  logic                       osd_enable_i,
    input  vout_pkg::osd_color_e       osd_color_i,
    input  vout_pkg::exp_sel_e         exp_sel_i,
    input  vout_pkg::extra_out_mode_e  extra_out_mode_i,
    output vout_pkg::chan_t            hdmi_r_o,
    output vout_pkg::chan_t            hdmi_g_o,
    output vout_pkg::chan_t            hdmi_b_o,
    output logic                       hdmi_hsync_o,
    output logic                       hdmi_vsync_o,
    output logic                       hdmi_de_o,
    output vout_pkg::chan_t            vga_r_o,
    output vout_pkg::chan_t            vga_g_o,
    output vout_pkg::chan_t            vga_b_o,
    output logic                       vga_hs_o,
    output logic                       vga_vs_o,
    output logic                       vga_blank_n_o,
    output logic                       vga_sync_n_o,
    output logic                       vga_oe_o
);

    vout_lane_if lane_bus ();

    logic                      hs_s1;
    logic                      vs_s1;
    logic                      de_s1;
    logic                      vga_en_s1;
    vout_pkg::extra_out_mode_e mode_s1;
    vout_pkg::chan_t           hdmi_lane [`VOUT_NUM_LANES];
    vout_pkg::chan_t           vga_lane  [`VOUT_NUM_LANES];

    osd_palette palette0 (
        .pclk_out         (pclk_out),
        .po_reset_n       (po_reset_n),
        .r_i              (r_i),
        .g_i              (g_i),
        .b_i              (b_i),
        .hsync_i          (hsync_i),
        .vsync_i          (vsync_i),
        .de_i             (de_i),
        .osd_enable_i     (osd_enable_i),
        .osd_color_i      (osd_color_i),
        .exp_sel_i        (exp_sel_i),
        .extra_out_mode_i (extra_out_mode_i),
        .lane_o           (lane_bus),
        .hs_s1_o          (hs_s1),
        .vs_s1_o          (vs_s1),
        .de_s1_o          (de_s1),
        .vga_en_s1_o      (vga_en_s1),
        .mode_s1_o        (mode_s1)
    );

    for (genvar i = 0; i < `VOUT_NUM_LANES; i++) begin : lane_gen
        pixel_lane #(
            .LANE (i)
        ) lane0 (
            .pclk_out   (pclk_out),
            .po_reset_n (po_reset_n),
            .lane_i     (lane_bus),
            .hdmi_o     (hdmi_lane[i]),
            .vga_o      (vga_lane[i])
        );
    end

    sync_encoder sync0 (
        .pclk_out      (pclk_out),
        .po_reset_n    (po_reset_n),
        .hs_s1_i       (hs_s1),
        .vs_s1_i       (vs_s1),
        .de_s1_i       (de_s1),
        .vga_en_s1_i   (vga_en_s1),
        .mode_s1_i     (mode_s1),
        .hdmi_hsync_o  (hdmi_hsync_o),
        .hdmi_vsync_o  (hdmi_vsync_o),
        .hdmi_de_o     (hdmi_de_o),
        .vga_hs_o      (vga_hs_o),
        .vga_vs_o      (vga_vs_o),
        .vga_blank_n_o (vga_blank_n_o),
        .vga_sync_n_o  (vga_sync_n_o),
        .vga_oe_o      (vga_oe_o)
    );

    assign hdmi_r_o = hdmi_lane[0];
    assign hdmi_g_o = hdmi_lane[1];
    assign hdmi_b_o = hdmi_lane[2];
    assign vga_r_o  = vga_lane[0];
    assign vga_g_o  = vga_lane[1];
    assign vga_b_o  = vga_lane[2];

endmodule

`default_nettype wire

// ==== video_out_checker.sv ====
// Video output stage checker
`timescale 1ns/1ns
`default_nettype none

`include "vout_cfg.svh"

module video_out_checker (
    input logic                pclk_out,
    input logic                po_reset_n,
    input vout_pkg::exp_sel_e  exp_sel_i,
    input logic                hdmi_de_o,
    input vout_pkg::chan_t     vga_r_o,
    input vout_pkg::chan_t     vga_g_o,
    input vout_pkg::chan_t     vga_b_o,
    input logic                vga_hs_o,
    input logic                vga_vs_o,
    input logic                vga_blank_n_o,
    input logic                vga_sync_n_o,
    input logic                vga_oe_o
);

    // Outputs stay at their reset levels while reset is held
    reset_quiet_a: assert property (@(posedge pclk_out)
        !po_reset_n |-> (!hdmi_de_o && !vga_oe_o && !vga_blank_n_o && !vga_sync_n_o))
        else $error("outputs not quiet during reset");

    // VGA port holds while extra-out is not selected
    vga_hold_a: assert property (@(posedge pclk_out) disable iff (!po_reset_n)
        (exp_sel_i != vout_pkg::EXP_EXTRA_OUT) |-> ##(`VOUT_VGA_LAT)
        ($stable(vga_r_o) && $stable(vga_g_o) && $stable(vga_b_o) &&
         $stable(vga_hs_o) && $stable(vga_vs_o) &&
         $stable(vga_blank_n_o) && $stable(vga_sync_n_o)))
        else $error("VGA outputs changed while extra-out was off");

    oe_on_a: assert property (@(posedge pclk_out) disable iff (!po_reset_n)
        (exp_sel_i == vout_pkg::EXP_EXTRA_OUT) |-> ##(`VOUT_VGA_LAT) vga_oe_o)
        else $error("vga_oe_o low with extra-out selected");

    oe_off_a: assert property (@(posedge pclk_out) disable iff (!po_reset_n)
        (exp_sel_i != vout_pkg::EXP_EXTRA_OUT) |-> ##(`VOUT_VGA_LAT) !vga_oe_o)
        else $error("vga_oe_o high without extra-out");

endmodule

bind video_out_top video_out_checker chk0 (.*);

`default_nettype wire

// ==== tb_video_out.sv ====
// Video output stage testbench
`timescale 1ns/1ns
`default_nettype none

`include "vout_cfg.svh"

module tb_video_out;

    localparam int CLK_PERIOD = 40;
    localparam int NROWS = 44;
    localparam int NTESTS = 7;

    typedef struct packed {
        logic [2:0]                test;
        logic [7:0]                r;
        logic [7:0]                g;
        logic [7:0]                b;
        logic                      hs;
        logic                      vs;
        logic                      de;
        logic                      osd;
        vout_pkg::osd_color_e      color;
        vout_pkg::exp_sel_e        exp_sel;
        vout_pkg::extra_out_mode_e mode;
    } row_t;

    logic pclk_out = 1'b0;
    logic po_reset_n;
    vout_pkg::chan_t r_i, g_i, b_i;
    logic hsync_i, vsync_i, de_i, osd_enable_i;
    vout_pkg::osd_color_e      osd_color_i;
    vout_pkg::exp_sel_e        exp_sel_i;
    vout_pkg::extra_out_mode_e extra_out_mode_i;
    vout_pkg::chan_t hdmi_r_o, hdmi_g_o, hdmi_b_o, vga_r_o, vga_g_o, vga_b_o;
    logic hdmi_hsync_o, hdmi_vsync_o, hdmi_de_o;
    logic vga_hs_o, vga_vs_o, vga_blank_n_o, vga_sync_n_o, vga_oe_o;

    row_t   rows [NROWS];
    int     checks [NTESTS];
    int     errors [NTESTS];
    string  names [NTESTS];
    bit     timed_out;
    integer seed;

    // Modelled VGA hold state
    logic [7:0] m_r, m_g, m_b;
    logic       m_hs, m_vs, m_bn, m_sn;

    video_out_top dut0 (.*);

    always #(CLK_PERIOD / 2) pclk_out = ~pclk_out;

    task automatic wait_edge(input bit rising);
        bit seen;
        int tries;
        seen = 0;
        tries = 0;
        while (!seen && tries < 3) begin
            fork
                begin
                    if (rising) @(posedge pclk_out);
                    else @(negedge pclk_out);
                    seen = 1;
                end
                #(2 * CLK_PERIOD);
            join_any
            disable fork;
            tries++;
        end
        if (!seen) begin
            $display("Timeout waiting for a clock edge at %0t", $time);
            timed_out = 1;
        end
    endtask

    task automatic check_val(input string name, input logic [7:0] got,
                             input logic [7:0] want, input int t);
        checks[t]++;
        assert (got === want) else begin
            $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, want);
            errors[t]++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want,
                             input int t);
        checks[t]++;
        assert (got === want) else begin
            $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, want);
            errors[t]++;
        end
    endtask

    function automatic logic [23:0] palette_rgb(input vout_pkg::osd_color_e c);
        case (c)
            vout_pkg::OSD_BLACK:  return 24'h000000;
            vout_pkg::OSD_BLUE:   return 24'h0000FF;
            vout_pkg::OSD_YELLOW: return 24'hFFFF00;
            default:              return 24'hFFFFFF;
        endcase
    endfunction

    function automatic logic [23:0] pixel_rgb(input row_t rw);
        if (rw.osd) return palette_rgb(rw.color);
        return {rw.r, rw.g, rw.b};
    endfunction

    function automatic void build_table();
        integer rnd;
        int t;
        for (int n = 0; n < NROWS; n++) begin
            t = (n < 8) ? 2 : (n < 16) ? 3 : (n < 24) ? 4 : (n < 36) ? 5 : 6;
            rnd = $random(seed);
            rows[n].test  = 3'(t);
            rows[n].r     = rnd[7:0];
            rows[n].g     = rnd[15:8];
            rows[n].b     = rnd[23:16];
            rows[n].hs    = rnd[24];
            rows[n].vs    = rnd[25];
            rows[n].de    = rnd[26];
            rows[n].osd   = (t == 3) || (t == 4 && n[0]);
            rows[n].color = vout_pkg::osd_color_e'(n[1:0]);
            rows[n].mode  = vout_pkg::EXTRA_RGBHV;
            if (t == 4 || t == 5) rows[n].exp_sel = vout_pkg::EXP_EXTRA_OUT;
            else if (t == 6 && n[0]) rows[n].exp_sel = vout_pkg::EXP_LEGACY_IN;
            else rows[n].exp_sel = vout_pkg::EXP_OFF;
            if (t == 5) rows[n].mode = vout_pkg::extra_out_mode_e'(2'(1 + (n - 24) / 4));
            if (t == 6) rows[n].mode = vout_pkg::extra_out_mode_e'(n[1:0]);
        end
    endfunction

    // VGA sync encoding per mode
    task automatic update_vga_model(input row_t rw);
        logic cs;
        cs = ~(rw.hs ^ rw.vs);
        {m_r, m_g, m_b} = pixel_rgb(rw);
        m_hs = cs;
        m_vs = 1'b1;
        m_bn = rw.de;
        m_sn = 1'b0;
        if (rw.mode == vout_pkg::EXTRA_RGBHV) begin
            m_hs = rw.hs;
            m_vs = rw.vs;
        end else if (rw.mode == vout_pkg::EXTRA_RGSB) begin
            m_sn = cs;
        end else if (rw.mode == vout_pkg::EXTRA_YPBPR) begin
            m_bn = 1'b1;
            m_sn = cs;
        end
    endtask

    task automatic print_test(input int t);
        $display("test %0d %s: %0d checks, %0d errors", t, names[t], checks[t], errors[t]);
    endtask

    initial begin
        int k;
        int t;
        int total_checks;
        int total_errors;
        logic [23:0] exp_rgb;
        row_t zero_row;
        row_t rw;

        names[1] = "reset values";
        names[2] = "HDMI passthrough";
        names[3] = "OSD palette";
        names[4] = "VGA RGBHV";
        names[5] = "VGA sync modes";
        names[6] = "VGA hold";
        for (int n = 0; n < NTESTS; n++) begin
            checks[n] = 0;
            errors[n] = 0;
        end
        seed = 19;
        timed_out = 0;
        zero_row = '0;
        {m_r, m_g, m_b, m_hs, m_vs, m_bn, m_sn} = '0;
        build_table();

        po_reset_n = 1'b0;
        {r_i, g_i, b_i} = '0;
        {hsync_i, vsync_i, de_i, osd_enable_i} = 4'b0000;
        osd_color_i = vout_pkg::OSD_BLACK;
        exp_sel_i = vout_pkg::EXP_OFF;
        extra_out_mode_i = vout_pkg::EXTRA_RGBHV;

        wait_edge(1'b1);
        wait_edge(1'b1);
        po_reset_n <= 1'b1;
        wait_edge(1'b0);
        check_bit("hdmi_de_o", hdmi_de_o, 1'b0, 1);
        check_val("vga_r_o", vga_r_o, 8'h00, 1);
        check_val("vga_g_o", vga_g_o, 8'h00, 1);
        check_val("vga_b_o", vga_b_o, 8'h00, 1);
        check_bit("vga_hs_o", vga_hs_o, 1'b0, 1);
        check_bit("vga_vs_o", vga_vs_o, 1'b0, 1);
        check_bit("vga_blank_n_o", vga_blank_n_o, 1'b0, 1);
        check_bit("vga_sync_n_o", vga_sync_n_o, 1'b0, 1);
        check_bit("vga_oe_o", vga_oe_o, 1'b0, 1);
        print_test(1);

        for (int i = 0; i < NROWS + 3; i++) begin
            wait_edge(1'b1);
            if (timed_out) break;
            if (i < NROWS) begin
                rw = rows[i];
                r_i <= rw.r;
                g_i <= rw.g;
                b_i <= rw.b;
                hsync_i <= rw.hs;
                vsync_i <= rw.vs;
                de_i <= rw.de;
                osd_enable_i <= rw.osd;
                osd_color_i <= rw.color;
                exp_sel_i <= rw.exp_sel;
                extra_out_mode_i <= rw.mode;
            end
            wait_edge(1'b0);
            if (timed_out) break;

            // HDMI port shows the row from 2 cycles earlier
            k = i - `VOUT_HDMI_LAT;
            if (k < NROWS) begin
                if (k >= 0) begin
                    rw = rows[k];
                    t = int'(rw.test);
                end else begin
                    rw = zero_row;
                    t = 2;
                end
                exp_rgb = pixel_rgb(rw);
                check_val("hdmi_r_o", hdmi_r_o, exp_rgb[23:16], t);
                check_val("hdmi_g_o", hdmi_g_o, exp_rgb[15:8], t);
                check_val("hdmi_b_o", hdmi_b_o, exp_rgb[7:0], t);
                check_bit("hdmi_hsync_o", hdmi_hsync_o, rw.hs, t);
                check_bit("hdmi_vsync_o", hdmi_vsync_o, rw.vs, t);
                check_bit("hdmi_de_o", hdmi_de_o, rw.de, t);
            end

            // VGA port shows the row from 3 cycles earlier or holds
            k = i - `VOUT_VGA_LAT;
            if (k >= 0) begin
                rw = rows[k];
                t = int'(rw.test);
            end else begin
                rw = zero_row;
                t = 2;
            end
            if (rw.exp_sel == vout_pkg::EXP_EXTRA_OUT) update_vga_model(rw);
            check_val("vga_r_o", vga_r_o, m_r, t);
            check_val("vga_g_o", vga_g_o, m_g, t);
            check_val("vga_b_o", vga_b_o, m_b, t);
            check_bit("vga_hs_o", vga_hs_o, m_hs, t);
            check_bit("vga_vs_o", vga_vs_o, m_vs, t);
            check_bit("vga_blank_n_o", vga_blank_n_o, m_bn, t);
            check_bit("vga_sync_n_o", vga_sync_n_o, m_sn, t);
            check_bit("vga_oe_o", vga_oe_o, rw.exp_sel == vout_pkg::EXP_EXTRA_OUT, t);
            if (k >= 0 && (k == NROWS - 1 || rows[k + 1].test != rows[k].test)) begin
                print_test(t);
            end
        end

        total_checks = 0;
        total_errors = 0;
        for (int n = 1; n < NTESTS; n++) begin
            total_checks += checks[n];
            total_errors += errors[n];
        end
        $display("checks %0d, errors %0d", total_checks, total_errors);
        if (!timed_out && total_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
vout_pkg.sv
vout_lane_if.sv
osd_palette.sv
pixel_lane.sv
sync_encoder.sv
video_out_top.sv
video_out_checker.sv
tb_video_out.sv
+incdir+.

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module tb_video_out -o sim_video_out

out=$(./obj_dir/sim_video_out)
echo "$out"

if echo "$out" | grep -qx "Verification passed"; then
    exit 0
else
    exit 1
fi
